//--- flist.f
+incdir+rtl
rtl/snn_pkg.sv
rtl/snn_scheduler.sv
rtl/snn_controller.sv
rtl/synaptic_core.sv
rtl/neuron_core.sv
rtl/aer_out.sv
rtl/snn_core.sv
tests/tb_clk_gen.sv
tests/snn_core_tb.sv

//--- Makefile
# Verilator build and run of the snn_core testbench

VERILATOR ?= verilator
TOP       ?= snn_core_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless the log reports a pass"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/snn_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "snn_defs.svh"

module snn_core_tb;
    import snn_pkg::*;

    localparam int N_POST    = `SNN_POST_NEURONS;
    localparam int MEM_MAX   = (1 << (`SNN_MEM_W - 1)) - 1;
    localparam int MEM_MIN   = -(1 << (`SNN_MEM_W - 1));
    localparam int CNT_MAX   = (1 << `SNN_CNT_W) - 1;
    localparam int TEST_LEN  = 1 + 2 + 25 + 5 + 39;   // events of all tests summed
    localparam int WDOG_NS   = TEST_LEN * 2000;
    localparam int WAIT_MAX  = 5000;                  // cycles per wait loop

    logic       CLK;
    logic       arst_n;
    aer_addr_t  aerin_addr;
    logic       aerin_req;
    logic       aerin_ack;
    syn_wr_t    syn_wr;
    aer_addr_t  aerout_addr;
    logic       aerout_req;
    logic       aerout_ack;
    logic       sample_done;
    goodness_t  goodness;

    integer     seed = 32'h8065_ef91;
    int         errors;
    int         tests_run;
    int         tests_failed;
    int         done_cnt;
    int         slow_extra;          // extra ack delay in test 5
    string      cur_test;

    // reference model state
    logic signed [7:0] w [16][16];   // [pre][post]
    int         mem_m [N_POST];
    int         cnt_m [N_POST];
    int         step_m;
    int         exp_goodness;
    int         exp_q [$];
    aer_addr_t  rx_q  [$];

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(5)) i_clk_gen (.CLK, .arst_n);

    snn_core i_snn_core (
        .CLK, .arst_n,
        .aerin_addr, .aerin_req, .aerin_ack,
        .syn_wr,
        .aerout_addr, .aerout_req, .aerout_ack,
        .sample_done, .goodness
    );

    // --------------------
    // concurrent checks
    done_pulse: assert property (@(posedge CLK) disable iff (!arst_n)
        sample_done |=> !sample_done)
        else begin
            $display("sample_done stayed high for more than one cycle in %s", cur_test);
            errors++;
        end

    good_at_done: assert property (@(posedge CLK) disable iff (!arst_n)
        sample_done |-> (goodness == goodness_t'(exp_goodness)))
        else begin
            $display("CHECK FAILED %s goodness expected %0d actual %0d",
                     cur_test, exp_goodness, goodness);
            errors++;
        end

    good_hold: assert property (@(posedge CLK) disable iff (!arst_n)
        (goodness != $past(goodness)) |-> sample_done)
        else begin
            $display("goodness changed outside a sample end in %s", cur_test);
            errors++;
        end

    always @(posedge CLK) begin
        if (sample_done)
            done_cnt <= done_cnt + 1;
    end

    // watchdog
    initial begin
        #(WDOG_NS);
        $display("run timed out after %0d ns, the DUT stopped responding", WDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // output aer receiver with a random ack delay
    initial begin
        int delay;
        forever begin
            @(posedge CLK);
            if (arst_n && aerout_req && !aerout_ack) begin
                delay = int'($unsigned($random(seed)) % 8) + slow_extra;
                repeat (delay) @(posedge CLK);
                rx_q.push_back(aerout_addr);
                aerout_ack <= 1'b1;
                do @(posedge CLK); while (aerout_req);
                aerout_ack <= 1'b0;
            end
        end
    end

    // --------------------
    // reference model
    function automatic int clamp_mem(int v);
        if (v > MEM_MAX) return MEM_MAX;
        if (v < MEM_MIN) return MEM_MIN;
        return v;
    endfunction

    function automatic void model_spike(int p);
        for (int n = 0; n < N_POST; n++)
            mem_m[n] = clamp_mem(mem_m[n] + int'(w[p][n]));
    endfunction

    function automatic void model_marker();
        int acc;
        int c;
        bit f;
        acc = 0;
        for (int n = 0; n < N_POST; n++) begin
            f = (mem_m[n] >= `SNN_THRESHOLD);
            c = cnt_m[n] + ((f && cnt_m[n] < CNT_MAX) ? 1 : 0);
            if (f)
                exp_q.push_back(n);
            if (step_m == `SNN_TIME_STEP - 1) begin
                acc += c * c;               // new spike counts too
                mem_m[n] = 0;
                cnt_m[n] = 0;
            end else if (f) begin
                mem_m[n] = 0;
                cnt_m[n] = c;
            end
        end
        if (step_m == `SNN_TIME_STEP - 1) begin
            exp_goodness = acc;
            step_m = 0;
        end else begin
            step_m++;
        end
    endfunction

    // --------------------
    // stimulus tasks
    task automatic load_weights();
        syn_word_t word;
        for (int p = 0; p < 16; p++) begin
            for (int g = 0; g < 4; g++) begin
                for (int i = 0; i < 4; i++)
                    word[i*8 +: 8] = w[p][g*4+i];
                @(posedge CLK);
                syn_wr.en   <= 1'b1;
                syn_wr.pre  <= pre_addr_t'(p);
                syn_wr.grp  <= group_t'(g);
                syn_wr.data <= word;
            end
        end
        @(posedge CLK);
        syn_wr <= '0;
    endtask

    // four-phase sender
    task automatic send_aer(input aer_addr_t a);
        @(posedge CLK);
        aerin_addr <= a;
        aerin_req  <= 1'b1;
        do @(posedge CLK); while (!aerin_ack);
        aerin_req <= 1'b0;
        do @(posedge CLK); while (aerin_ack);
    endtask

    task automatic spike(input int p);
        model_spike(p);
        send_aer(aer_addr_t'(p));
    endtask

    task automatic marker();
        model_marker();
        send_aer(8'h80);
    endtask

    task automatic wait_done(input int start);
        int t;
        t = 0;
        while (done_cnt == start && t < WAIT_MAX) begin
            @(posedge CLK);
            t++;
        end
        if (done_cnt == start) begin
            $display("%s: sample_done never pulsed", cur_test);
            errors++;
        end
    endtask

    // compare received addresses with the model, then clear both
    task automatic check_outputs();
        int t;
        t = 0;
        while (rx_q.size() < exp_q.size() && t < WAIT_MAX) begin
            @(posedge CLK);
            t++;
        end
        repeat (60) @(posedge CLK);   // let stray events show up
        no_extra: assert (rx_q.size() == exp_q.size())
            else begin
                $display("CHECK FAILED %s output count expected %0d actual %0d",
                         cur_test, exp_q.size(), rx_q.size());
                errors++;
            end
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            addr_ok: assert (int'(rx_q[i]) == exp_q[i])
                else begin
                    $display("CHECK FAILED %s output %0d expected %0d actual %0d",
                             cur_test, i, exp_q[i], rx_q[i]);
                    errors++;
                end
        end
        exp_q.delete();
        rx_q.delete();
    endtask

    task automatic end_test(input int errs_before);
        tests_run++;
        if (errors != errs_before)
            tests_failed++;
        $display("[test] %-12s %s", cur_test, (errors == errs_before) ? "passed" : "failed");
    endtask

    // --------------------
    // main sequence
    initial begin
        int e0;
        int d0;
        int r;
        aerin_addr <= '0;
        aerin_req  <= 1'b0;
        syn_wr     <= '0;
        aerout_ack <= 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        done_cnt = 0;
        slow_extra = 0;
        exp_goodness = 0;
        step_m = 0;
        for (int n = 0; n < N_POST; n++) begin
            mem_m[n] = 0;
            cnt_m[n] = 0;
        end
        for (int p = 0; p < 16; p++)
            for (int n = 0; n < 16; n++)
                w[p][n] = 8'sd0;

        // row 0 crosses threshold at 2 and 9, leaves residue elsewhere
        for (int n = 0; n < 16; n++)
            w[0][n] = (n % 3 == 0) ? -8'sd5 : 8'sd10;
        w[0][2] = 8'sd64;
        w[0][9] = 8'sd70;
        // rows 1 and 2 sum to the threshold only together
        w[1][5] = 8'sd30;
        w[1][6] = -8'sd20;
        w[2][5] = 8'sd34;
        w[2][6] = 8'sd40;
        w[2][7] = 8'sd20;
        // row 3 saturates 12 upward and 13 downward
        w[3][12] = 8'sd127;
        w[3][13] = -8'sd128;

        cur_test = "reset";
        @(posedge arst_n);
        @(posedge CLK);
        e0 = errors;
        rst_vals: assert (!aerin_ack && !aerout_req && !sample_done && goodness == '0)
            else begin
                $display("CHECK FAILED %s outputs expected 0 actual ack=%b req=%b done=%b good=%0d",
                         cur_test, aerin_ack, aerout_req, sample_done, goodness);
                errors++;
            end
        end_test(e0);
        load_weights();

        cur_test = "two_fire";
        e0 = errors;
        spike(0);
        marker();
        check_outputs();
        end_test(e0);

        cur_test = "accumulate";
        e0 = errors;
        spike(1);
        marker();                    // 5 still below
        spike(2);
        spike(1);
        for (int k = 0; k < 20; k++)
            spike(3);                // 20 x 127 would wrap
        marker();
        check_outputs();
        end_test(e0);

        cur_test = "sample_end";
        e0 = errors;
        d0 = done_cnt;
        marker();                    // last step of the sample
        wait_done(d0);
        good_end: assert (goodness == goodness_t'(exp_goodness))
            else begin
                $display("CHECK FAILED %s goodness expected %0d actual %0d",
                         cur_test, exp_goodness, goodness);
                errors++;
            end
        check_outputs();
        spike(0);                    // fresh sample on cleared membranes
        spike(2);
        spike(2);                    // 7 fires only with the old 30 left over
        marker();
        check_outputs();
        end_test(e0);

        cur_test = "random_burst";
        e0 = errors;
        for (int p = 8; p < 16; p++)
            for (int n = 0; n < 16; n++) begin
                r = int'($unsigned($random(seed)) % 71) - 20;
                w[p][n] = 8'(r);
            end
        load_weights();
        slow_extra = 10;
        d0 = done_cnt;
        for (int s = 0; s < `SNN_TIME_STEP - 1; s++) begin
            for (int k = 0; k < 12; k++)   // overruns the scheduler while a sweep stalls
                spike(8 + int'($unsigned($random(seed)) % 8));
            marker();
        end
        wait_done(d0);
        check_outputs();
        end_test(e0);

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic CLK,
    output logic arst_n
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // reset released on a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/snn_core.sv
`timescale 1ns/1ps
`default_nettype none

module snn_core (
    input  wire logic               CLK,
    input  wire logic               arst_n,
    input  wire snn_pkg::aer_addr_t aerin_addr,
    input  wire logic               aerin_req,
    output logic                    aerin_ack,
    input  wire snn_pkg::syn_wr_t   syn_wr,
    output snn_pkg::aer_addr_t      aerout_addr,
    output logic                    aerout_req,
    input  wire logic               aerout_ack,
    output logic                    sample_done,
    output snn_pkg::goodness_t      goodness
);
    import snn_pkg::*;

    // --------------------
    // internal links
    aer_addr_t  sched_event;
    logic       sched_empty;
    logic       sched_pop;
    syn_rd_t    syn_rd;
    syn_word_t  syn_rdata;
    neur_op_t   neur_op;
    logic       fire_valid;
    post_addr_t fire_addr;
    logic       aerout_full;

    snn_scheduler i_scheduler (
        .CLK, .arst_n,
        .aerin_addr, .aerin_req, .aerin_ack,
        .sched_pop, .sched_event, .sched_empty
    );

    snn_controller i_controller (
        .CLK, .arst_n,
        .sched_event, .sched_empty, .sched_pop,
        .syn_rd, .neur_op,
        .aerout_full, .sample_done
    );

    synaptic_core i_synaptic_core (
        .CLK, .syn_wr, .syn_rd, .syn_rdata
    );

    neuron_core i_neuron_core (
        .CLK, .arst_n,
        .neur_op, .syn_rdata,
        .fire_valid, .fire_addr, .goodness
    );

    aer_out i_aer_out (
        .CLK, .arst_n,
        .fire_valid, .fire_addr, .aerout_full,
        .aerout_addr, .aerout_req, .aerout_ack
    );

endmodule

`default_nettype wire

//--- rtl/aer_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "snn_defs.svh"

module aer_out (
    input  wire logic                CLK,
    input  wire logic                arst_n,
    input  wire logic                fire_valid,
    input  wire snn_pkg::post_addr_t fire_addr,
    output logic                     aerout_full,
    output snn_pkg::aer_addr_t       aerout_addr,
    output logic                     aerout_req,
    input  wire logic                aerout_ack
);
    import snn_pkg::*;

    localparam int DEPTH = `SNN_AEROUT_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    post_addr_t    fifo_mem [DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic [AW:0]   count_q;
    logic          ack_s1, ack_s2;   // ack sync chain
    logic          push, pop;

    // one slot spare for the fire already in the neuron pipe
    assign aerout_full = (count_q >= (AW+1)'(DEPTH - 1));
    assign push        = fire_valid && (count_q != (AW+1)'(DEPTH));
    // launch only with link idle, ack fully returned low
    assign pop         = !aerout_req && !ack_s2 && (count_q != '0);

    // --------------------
    // fifo control and four-phase sender
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count_q    <= '0;
            ack_s1     <= 1'b0;
            ack_s2     <= 1'b0;
            aerout_req <= 1'b0;
        end else begin
            ack_s1 <= aerout_ack;
            ack_s2 <= ack_s1;
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count_q <= count_q + (AW+1)'(push) - (AW+1)'(pop);
            if (pop)
                aerout_req <= 1'b1;
            else if (aerout_req && ack_s2)
                aerout_req <= 1'b0;            // receiver took it
        end
    end

    always_ff @(posedge CLK) begin
        if (push)
            fifo_mem[wr_ptr] <= fire_addr;
        if (pop)
            aerout_addr <= aer_addr_t'(fifo_mem[rd_ptr]);  // stable before req rises
    end

endmodule

`default_nettype wire

//--- rtl/neuron_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "snn_defs.svh"

module neuron_core (
    input  wire logic              CLK,
    input  wire logic              arst_n,
    input  wire snn_pkg::neur_op_t neur_op,
    input  wire snn_pkg::syn_word_t syn_rdata,
    output logic                   fire_valid,
    output snn_pkg::post_addr_t    fire_addr,
    output snn_pkg::goodness_t     goodness
);
    import snn_pkg::*;

    localparam int         N         = `SNN_POST_NEURONS;
    localparam membrane_t  THRESHOLD = membrane_t'(`SNN_THRESHOLD);
    localparam post_addr_t LAST_IDX  = post_addr_t'(N - 1);

    membrane_t  mem_q [N];
    spike_cnt_t cnt_q [N];
    goodness_t  acc_q;          // running sum of squares
    logic       spike;
    spike_cnt_t cnt_new;
    goodness_t  acc_new;

    // signed add, clamps instead of wrapping
    function automatic membrane_t sat_add(membrane_t a, weight_t w);
        logic signed [`SNN_MEM_W:0] s;
        s = $signed({a[`SNN_MEM_W-1], a}) + $signed(w);
        if (s[`SNN_MEM_W] != s[`SNN_MEM_W-1])
            return s[`SNN_MEM_W] ? {1'b1, {(`SNN_MEM_W-1){1'b0}}} : {1'b0, {(`SNN_MEM_W-1){1'b1}}};
        return s[`SNN_MEM_W-1:0];
    endfunction

    // --------------------
    // fire path of the swept neuron
    always_comb begin
        spike   = neur_op.fire && (mem_q[neur_op.post] >= THRESHOLD);
        cnt_new = cnt_q[neur_op.post];
        if (spike && cnt_new != '1)
            cnt_new = cnt_new + 1'b1;                  // saturating count
        acc_new = acc_q + goodness_t'(cnt_new) * goodness_t'(cnt_new);
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 0; n < N; n++) begin
                mem_q[n] <= '0;
                cnt_q[n] <= '0;
            end
            acc_q      <= '0;
            goodness   <= '0;
            fire_valid <= 1'b0;
        end else begin
            fire_valid <= spike;
            if (neur_op.integ) begin
                for (int i = 0; i < `SNN_PARALLEL; i++) begin
                    mem_q[post_addr_t'(int'(neur_op.grp) * `SNN_PARALLEL + i)] <=
                        sat_add(mem_q[post_addr_t'(int'(neur_op.grp) * `SNN_PARALLEL + i)],
                                weight_t'(syn_rdata[i*`SNN_WEIGHT_W +: `SNN_WEIGHT_W]));
                end
            end
            if (neur_op.fire) begin
                if (neur_op.last) begin
                    mem_q[neur_op.post] <= '0;         // sample over, clear neuron
                    cnt_q[neur_op.post] <= '0;
                    if (neur_op.post == LAST_IDX) begin
                        goodness <= acc_new;           // held until next sample end
                        acc_q    <= '0;
                    end else begin
                        acc_q    <= acc_new;
                    end
                end else if (spike) begin
                    mem_q[neur_op.post] <= '0;
                    cnt_q[neur_op.post] <= cnt_new;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        fire_addr <= neur_op.post;   // qualified by fire_valid
    end

endmodule

`default_nettype wire

//--- rtl/synaptic_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "snn_defs.svh"

module synaptic_core (
    input  wire logic             CLK,
    input  wire snn_pkg::syn_wr_t syn_wr,
    input  wire snn_pkg::syn_rd_t syn_rd,
    output snn_pkg::syn_word_t    syn_rdata
);
    import snn_pkg::*;

    localparam int WORDS_PER_ROW = `SNN_POST_NEURONS / `SNN_PARALLEL;
    localparam int WORDS         = `SNN_PRE_NEURONS * WORDS_PER_ROW;  // 64
    localparam int AW            = $clog2(WORDS);

    // --------------------
    // row-major, {pre, grp} addressing
    syn_word_t      syn_mem [WORDS];
    logic [AW-1:0]  wr_addr;
    logic [AW-1:0]  rd_addr;

    assign wr_addr = {syn_wr.pre, syn_wr.grp};
    assign rd_addr = {syn_rd.pre, syn_rd.grp};

    // weight load, idle only
    always_ff @(posedge CLK) begin
        if (syn_wr.en)
            syn_mem[wr_addr] <= syn_wr.data;
    end

    // registered read
    // data valid the cycle after en
    always_ff @(posedge CLK) begin
        if (syn_rd.en)
            syn_rdata <= syn_mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- rtl/snn_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "snn_defs.svh"

module snn_controller (
    input  wire logic               CLK,
    input  wire logic               arst_n,
    input  wire snn_pkg::aer_addr_t sched_event,
    input  wire logic               sched_empty,
    output logic                    sched_pop,
    output snn_pkg::syn_rd_t        syn_rd,
    output snn_pkg::neur_op_t       neur_op,
    input  wire logic               aerout_full,
    output logic                    sample_done
);
    import snn_pkg::*;

    localparam int         STEP_W     = $clog2(`SNN_TIME_STEP);
    localparam int         MARK_BIT   = `SNN_AER_W - 1;
    localparam group_t     GRP_LAST   = group_t'(`SNN_POST_NEURONS / `SNN_PARALLEL - 1);
    localparam post_addr_t SWEEP_LAST = post_addr_t'(`SNN_POST_NEURONS - 1);

    ctrl_state_t         state_q;
    group_t              grp_q;      // synapse word being read
    post_addr_t          sweep_q;    // neuron under threshold check
    logic [STEP_W-1:0]   step_q;     // markers seen this sample
    pre_addr_t           pre_q;      // row of current spike
    logic                int_vld_q;  // read issued last cycle
    group_t              int_grp_q;
    logic                last_step;

    assign last_step   = (step_q == STEP_W'(`SNN_TIME_STEP - 1));
    assign sample_done = (state_q == DONE);          // one cycle pulse
    assign sched_pop   = (state_q == IDLE) && !sched_empty;

    // --------------------
    // synapse read, comb from state
    always_comb begin
        syn_rd     = '0;
        syn_rd.en  = (state_q == INTEGRATE);
        syn_rd.pre = pre_q;
        syn_rd.grp = grp_q;
    end

    // integrate op lines up with registered syn_rdata
    always_comb begin
        neur_op       = '0;
        neur_op.integ = int_vld_q;
        neur_op.grp   = int_grp_q;
        if (state_q == FIRE) begin
            neur_op.fire = !aerout_full;   // hold the sweep while output is backed up
            neur_op.post = sweep_q;
            neur_op.last = last_step;
        end
    end

    // --------------------
    // main fsm
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= IDLE;
            grp_q     <= '0;
            sweep_q   <= '0;
            step_q    <= '0;
            int_vld_q <= 1'b0;
        end else begin
            int_vld_q <= syn_rd.en;
            case (state_q)
                IDLE: begin
                    if (!sched_empty) begin
                        if (sched_event[MARK_BIT]) begin
                            state_q <= FIRE;       // time-step marker
                            sweep_q <= '0;
                        end else begin
                            state_q <= INTEGRATE;  // spike from pre neuron
                            grp_q   <= '0;
                        end
                    end
                end
                INTEGRATE: begin
                    grp_q <= grp_q + 1'b1;
                    if (grp_q == GRP_LAST)
                        state_q <= IDLE;
                end
                FIRE: begin
                    if (!aerout_full) begin
                        sweep_q <= sweep_q + 1'b1;
                        if (sweep_q == SWEEP_LAST) begin
                            if (last_step) begin
                                state_q <= DONE;
                            end else begin
                                state_q <= IDLE;
                                step_q  <= step_q + 1'b1;
                            end
                        end
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                    step_q  <= '0;                 // next sample
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (sched_pop)
            pre_q <= pre_addr_t'(sched_event[$bits(pre_addr_t)-1:0]);
        int_grp_q <= grp_q;
    end

endmodule

`default_nettype wire

//--- rtl/snn_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "snn_defs.svh"

module snn_scheduler (
    input  wire logic              CLK,
    input  wire logic              arst_n,
    input  wire snn_pkg::aer_addr_t aerin_addr,
    input  wire logic              aerin_req,
    output logic                   aerin_ack,
    input  wire logic              sched_pop,
    output snn_pkg::aer_addr_t     sched_event,
    output logic                   sched_empty
);
    import snn_pkg::*;

    localparam int DEPTH = `SNN_SCHED_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic          req_s1, req_s2;      // req sync chain
    logic [AW:0]   wr_ptr, rd_ptr;      // extra wrap bit
    aer_addr_t     fifo_mem [DEPTH];
    logic          fifo_full;
    logic          push;

    // --------------------
    // fifo flags
    assign sched_empty = (wr_ptr == rd_ptr);
    assign fifo_full   = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign sched_event = fifo_mem[rd_ptr[AW-1:0]];   // head, valid when not empty

    // new request only while ack is low, stalls when full
    assign push = req_s2 && !aerin_ack && !fifo_full;

    // --------------------
    // four-phase receiver
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            req_s1    <= 1'b0;
            req_s2    <= 1'b0;
            aerin_ack <= 1'b0;
        end else begin
            req_s1 <= aerin_req;
            req_s2 <= req_s1;
            if (push)
                aerin_ack <= 1'b1;              // address is stored
            else if (!req_s2 && aerin_ack)
                aerin_ack <= 1'b0;              // sender released req
        end
    end

    // --------------------
    // pointers
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (sched_pop && !sched_empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (push)
            fifo_mem[wr_ptr[AW-1:0]] <= aerin_addr;  // addr stable while req high
    end

endmodule

`default_nettype wire

//--- rtl/snn_pkg.sv
`default_nettype none

`include "snn_defs.svh"

package snn_pkg;

    typedef logic        [`SNN_AER_W-1:0]                       aer_addr_t;
    typedef logic        [$clog2(`SNN_PRE_NEURONS)-1:0]         pre_addr_t;
    typedef logic        [$clog2(`SNN_POST_NEURONS)-1:0]        post_addr_t;
    typedef logic        [$clog2(`SNN_POST_NEURONS/`SNN_PARALLEL)-1:0] group_t;
    typedef logic signed [`SNN_WEIGHT_W-1:0]                    weight_t;
    typedef logic        [`SNN_PARALLEL*`SNN_WEIGHT_W-1:0]      syn_word_t; // slice i -> neuron grp*4+i
    typedef logic signed [`SNN_MEM_W-1:0]                       membrane_t;
    typedef logic        [`SNN_CNT_W-1:0]                       spike_cnt_t;
    typedef logic        [`SNN_GOODNESS_W-1:0]                  goodness_t;

    // weight load port
    typedef struct packed {
        logic      en;
        pre_addr_t pre;
        group_t    grp;
        syn_word_t data;
    } syn_wr_t;

    typedef struct packed {
        logic      en;
        pre_addr_t pre;
        group_t    grp;
    } syn_rd_t;

    // controller -> neuron core command
    typedef struct packed {
        logic       integ;  // add syn_rdata into group grp
        group_t     grp;
        logic       fire;   // threshold check of neuron post
        post_addr_t post;
        logic       last;   // final step, fold into goodness and clear
    } neur_op_t;

    typedef enum logic [1:0] {IDLE, INTEGRATE, FIRE, DONE} ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/snn_defs.svh
`ifndef SNN_DEFS_SVH
`define SNN_DEFS_SVH

// --------------------
// network size
`define SNN_PRE_NEURONS    16   // input neurons
`define SNN_POST_NEURONS   16   // output neurons
`define SNN_PARALLEL       4    // weights per synapse word

// --------------------
// datapath widths
`define SNN_WEIGHT_W       8    // signed weight
`define SNN_MEM_W          12   // signed, saturating membrane
`define SNN_CNT_W          4    // spike counter
`define SNN_AER_W          8    // aer address, msb marks a time step
`define SNN_GOODNESS_W     32

// --------------------
// behaviour and buffering
`define SNN_THRESHOLD      64
`define SNN_TIME_STEP      4    // markers per sample
`define SNN_SCHED_DEPTH    8
`define SNN_AEROUT_DEPTH   8

`endif
